// File: logic/rv_pipe_macros.svh
`ifndef RV_PIPE_MACROS_SVH
`define RV_PIPE_MACROS_SVH

// Data path and register index widths
`define RV_XLEN 32
`define RV_REG_ADDR_W 5

// Fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`define RV_PC_STEP 32'd4

// ADDI x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// File: logic/rv_pipe_pkg.sv
`include "rv_pipe_macros.svh"

package rv_pipe_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic {SRC_B_REG, SRC_B_IMM} alu_src_b_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_kind_e;

  // Value written back to rd
  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC_STEP} result_src_e;

  typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE, BR_JUMP} branch_kind_e;

  typedef enum logic [1:0] {PC_SRC_STEP, PC_SRC_TARGET, PC_SRC_REG_TARGET} pc_src_e;

  typedef enum logic [1:0] {FWD_NONE, FWD_MEMORY, FWD_WRITEBACK} fwd_sel_e;

endpackage

// File: logic/rv_decoder.sv
module rv_decoder (
  input  rv_pipe_pkg::word_t        instr,
  output rv_pipe_pkg::reg_addr_t    rs1,
  output rv_pipe_pkg::reg_addr_t    rs2,
  output rv_pipe_pkg::reg_addr_t    rd,
  output rv_pipe_pkg::word_t        imm,
  output rv_pipe_pkg::alu_op_e      alu_op,
  output rv_pipe_pkg::alu_src_b_e   alu_src_b,
  output rv_pipe_pkg::result_src_e  result_src,
  output rv_pipe_pkg::branch_kind_e branch_kind,
  output logic                      reg_write,
  output logic                      mem_write,
  output logic                      jalr
);

  rv_pipe_pkg::opcode_e   opcode;
  rv_pipe_pkg::imm_kind_e imm_kind;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic                   use_rs1;
  logic                   use_rs2;

  assign opcode = rv_pipe_pkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    // Anything not listed below behaves as a NOP
    alu_op      = rv_pipe_pkg::ALU_ADD;
    alu_src_b   = rv_pipe_pkg::SRC_B_IMM;
    result_src  = rv_pipe_pkg::RES_ALU;
    branch_kind = rv_pipe_pkg::BR_NONE;
    imm_kind    = rv_pipe_pkg::IMM_I;
    reg_write   = 1'b0;
    mem_write   = 1'b0;
    jalr        = 1'b0;
    use_rs1     = 1'b0;
    use_rs2     = 1'b0;
    case (opcode)
      rv_pipe_pkg::OPC_OP: begin
        alu_src_b = rv_pipe_pkg::SRC_B_REG;
        reg_write = 1'b1;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        case (funct3)
          3'b000:  alu_op = funct7[5] ? rv_pipe_pkg::ALU_SUB : rv_pipe_pkg::ALU_ADD;
          3'b010:  alu_op = rv_pipe_pkg::ALU_SLT;
          3'b100:  alu_op = rv_pipe_pkg::ALU_XOR;
          3'b110:  alu_op = rv_pipe_pkg::ALU_OR;
          3'b111:  alu_op = rv_pipe_pkg::ALU_AND;
          default: reg_write = 1'b0;
        endcase
      end
      rv_pipe_pkg::OPC_OP_IMM: begin
        // ADDI only
        reg_write = (funct3 == 3'b000);
        use_rs1   = 1'b1;
      end
      rv_pipe_pkg::OPC_LUI: begin
        alu_op    = rv_pipe_pkg::ALU_PASS_B;
        imm_kind  = rv_pipe_pkg::IMM_U;
        reg_write = 1'b1;
      end
      rv_pipe_pkg::OPC_LOAD: begin
        result_src = rv_pipe_pkg::RES_MEM;
        reg_write  = 1'b1;
        use_rs1    = 1'b1;
      end
      rv_pipe_pkg::OPC_STORE: begin
        imm_kind  = rv_pipe_pkg::IMM_S;
        mem_write = 1'b1;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
      end
      rv_pipe_pkg::OPC_BRANCH: begin
        alu_op    = rv_pipe_pkg::ALU_SUB;
        alu_src_b = rv_pipe_pkg::SRC_B_REG;
        imm_kind  = rv_pipe_pkg::IMM_B;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        if (funct3 == 3'b000) begin
          branch_kind = rv_pipe_pkg::BR_BEQ;
        end else if (funct3 == 3'b001) begin
          branch_kind = rv_pipe_pkg::BR_BNE;
        end
      end
      rv_pipe_pkg::OPC_JAL: begin
        imm_kind    = rv_pipe_pkg::IMM_J;
        result_src  = rv_pipe_pkg::RES_PC_STEP;
        branch_kind = rv_pipe_pkg::BR_JUMP;
        reg_write   = 1'b1;
      end
      rv_pipe_pkg::OPC_JALR: begin
        result_src  = rv_pipe_pkg::RES_PC_STEP;
        branch_kind = rv_pipe_pkg::BR_JUMP;
        reg_write   = 1'b1;
        jalr        = 1'b1;
        use_rs1     = 1'b1;
      end
      default: ;
    endcase
  end

  // Unused source fields read as x0 so they never trigger a stall
  assign rs1 = use_rs1 ? instr[19:15] : '0;
  assign rs2 = use_rs2 ? instr[24:20] : '0;
  assign rd  = instr[11:7];

  always_comb begin
    case (imm_kind)
      rv_pipe_pkg::IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      rv_pipe_pkg::IMM_B: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                 instr[11:8], 1'b0};
      rv_pipe_pkg::IMM_U: imm = {instr[31:12], 12'b0};
      rv_pipe_pkg::IMM_J: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                 instr[30:21], 1'b0};
      default:            imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

endmodule

// File: logic/rv_register_file.sv
module rv_register_file (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rv_pipe_pkg::reg_addr_t ra1,
  input  rv_pipe_pkg::reg_addr_t ra2,
  output rv_pipe_pkg::word_t     rd1,
  output rv_pipe_pkg::word_t     rd2,
  input  rv_pipe_pkg::reg_addr_t wa,
  input  logic                   we,
  input  rv_pipe_pkg::word_t     wd
);

  rv_pipe_pkg::word_t regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

  // Writeback value is visible to decode in the same cycle
  assign rd1 = (we && wa != '0 && wa == ra1) ? wd : regs[ra1];
  assign rd2 = (we && wa != '0 && wa == ra2) ? wd : regs[ra2];

endmodule

// File: logic/rv_execute_unit.sv
module rv_execute_unit (
  input  rv_pipe_pkg::word_t        rd1,
  input  rv_pipe_pkg::word_t        rd2,
  input  rv_pipe_pkg::fwd_sel_e     fwd_a,
  input  rv_pipe_pkg::fwd_sel_e     fwd_b,
  input  rv_pipe_pkg::word_t        mem_result,
  input  rv_pipe_pkg::word_t        wb_result,
  input  rv_pipe_pkg::word_t        imm,
  input  rv_pipe_pkg::word_t        pc,
  input  rv_pipe_pkg::alu_op_e      alu_op,
  input  rv_pipe_pkg::alu_src_b_e   alu_src_b,
  input  rv_pipe_pkg::branch_kind_e branch_kind,
  input  logic                      jalr,
  output rv_pipe_pkg::word_t        alu_result,
  output rv_pipe_pkg::word_t        store_data,
  output rv_pipe_pkg::word_t        pc_target,
  output rv_pipe_pkg::pc_src_e      pc_src
);

  rv_pipe_pkg::word_t src_a;
  rv_pipe_pkg::word_t src_b_reg;
  rv_pipe_pkg::word_t alu_b;
  rv_pipe_pkg::word_t reg_target;
  logic               equal;

  function automatic rv_pipe_pkg::word_t pick_operand(
    input rv_pipe_pkg::fwd_sel_e sel,
    input rv_pipe_pkg::word_t    reg_val,
    input rv_pipe_pkg::word_t    mem_val,
    input rv_pipe_pkg::word_t    wb_val
  );
    case (sel)
      rv_pipe_pkg::FWD_MEMORY:    return mem_val;
      rv_pipe_pkg::FWD_WRITEBACK: return wb_val;
      default:                    return reg_val;
    endcase
  endfunction

  assign src_a      = pick_operand(fwd_a, rd1, mem_result, wb_result);
  assign src_b_reg  = pick_operand(fwd_b, rd2, mem_result, wb_result);
  assign alu_b      = (alu_src_b == rv_pipe_pkg::SRC_B_IMM) ? imm : src_b_reg;
  assign store_data = src_b_reg;

  always_comb begin
    case (alu_op)
      rv_pipe_pkg::ALU_SUB: alu_result = src_a - alu_b;
      rv_pipe_pkg::ALU_AND: alu_result = src_a & alu_b;
      rv_pipe_pkg::ALU_OR:  alu_result = src_a | alu_b;
      rv_pipe_pkg::ALU_XOR: alu_result = src_a ^ alu_b;
      rv_pipe_pkg::ALU_SLT: alu_result = rv_pipe_pkg::word_t'($signed(src_a) < $signed(alu_b));
      rv_pipe_pkg::ALU_PASS_B: alu_result = alu_b;
      default:              alu_result = src_a + alu_b;
    endcase
  end

  // JALR target drops bit 0
  assign reg_target = (src_a + imm) & ~rv_pipe_pkg::word_t'(1);
  assign pc_target  = jalr ? reg_target : pc + imm;
  assign equal      = (src_a == src_b_reg);

  always_comb begin
    pc_src = rv_pipe_pkg::PC_SRC_STEP;
    case (branch_kind)
      rv_pipe_pkg::BR_BEQ: begin
        if (equal) pc_src = rv_pipe_pkg::PC_SRC_TARGET;
      end
      rv_pipe_pkg::BR_BNE: begin
        if (!equal) pc_src = rv_pipe_pkg::PC_SRC_TARGET;
      end
      rv_pipe_pkg::BR_JUMP: begin
        pc_src = jalr ? rv_pipe_pkg::PC_SRC_REG_TARGET : rv_pipe_pkg::PC_SRC_TARGET;
      end
      default: ;
    endcase
  end

endmodule

// File: logic/rv_hazard_unit.sv
module rv_hazard_unit (
  input  rv_pipe_pkg::reg_addr_t   rs1_d,
  input  rv_pipe_pkg::reg_addr_t   rs2_d,
  input  rv_pipe_pkg::reg_addr_t   rs1_e,
  input  rv_pipe_pkg::reg_addr_t   rs2_e,
  input  rv_pipe_pkg::reg_addr_t   rd_e,
  input  rv_pipe_pkg::reg_addr_t   rd_m,
  input  rv_pipe_pkg::reg_addr_t   rd_w,
  input  logic                     reg_write_m,
  input  logic                     reg_write_w,
  input  rv_pipe_pkg::result_src_e result_src_e,
  input  rv_pipe_pkg::pc_src_e     pc_src_e,
  output rv_pipe_pkg::fwd_sel_e    fwd_a,
  output rv_pipe_pkg::fwd_sel_e    fwd_b,
  output logic                     stall_f,
  output logic                     stall_d,
  output logic                     flush_d,
  output logic                     flush_e
);

  logic load_use;
  logic redirect;

  // Youngest producer wins
  function automatic rv_pipe_pkg::fwd_sel_e select_source(input rv_pipe_pkg::reg_addr_t rs);
    if (rs != '0 && reg_write_m && rs == rd_m) begin
      return rv_pipe_pkg::FWD_MEMORY;
    end else if (rs != '0 && reg_write_w && rs == rd_w) begin
      return rv_pipe_pkg::FWD_WRITEBACK;
    end
    return rv_pipe_pkg::FWD_NONE;
  endfunction

  assign fwd_a = select_source(rs1_e);
  assign fwd_b = select_source(rs2_e);

  // Load data only exists after the memory stage
  assign load_use = (result_src_e == rv_pipe_pkg::RES_MEM) && (rd_e != '0) &&
                    (rs1_d == rd_e || rs2_d == rd_e);
  assign redirect = (pc_src_e != rv_pipe_pkg::PC_SRC_STEP);

  assign stall_f = load_use;
  assign stall_d = load_use;
  assign flush_d = redirect;
  assign flush_e = load_use || redirect;

endmodule

// File: logic/rv_pipe_core.sv
`include "rv_pipe_macros.svh"

module rv_pipe_core (
  input  logic               clk,
  input  logic               rst_n,
  output rv_pipe_pkg::word_t instr_addr,
  input  rv_pipe_pkg::word_t instr_data,
  output rv_pipe_pkg::word_t data_addr,
  output rv_pipe_pkg::word_t data_wdata,
  output logic               data_we,
  input  rv_pipe_pkg::word_t data_rdata
);

  logic                  stall_f;
  logic                  stall_d;
  logic                  flush_d;
  logic                  flush_e;
  rv_pipe_pkg::fwd_sel_e fwd_a;
  rv_pipe_pkg::fwd_sel_e fwd_b;

  // Fetch
  rv_pipe_pkg::word_t pc_f;
  rv_pipe_pkg::word_t pc_next;

  // Decode
  rv_pipe_pkg::word_t        instr_d;
  rv_pipe_pkg::word_t        pc_d;
  rv_pipe_pkg::reg_addr_t    rs1_d;
  rv_pipe_pkg::reg_addr_t    rs2_d;
  rv_pipe_pkg::reg_addr_t    rd_d;
  rv_pipe_pkg::word_t        imm_d;
  rv_pipe_pkg::word_t        rd1_d;
  rv_pipe_pkg::word_t        rd2_d;
  rv_pipe_pkg::alu_op_e      alu_op_d;
  rv_pipe_pkg::alu_src_b_e   alu_src_b_d;
  rv_pipe_pkg::result_src_e  result_src_d;
  rv_pipe_pkg::branch_kind_e branch_kind_d;
  logic                      reg_write_d;
  logic                      mem_write_d;
  logic                      jalr_d;

  // Execute
  rv_pipe_pkg::reg_addr_t    rs1_e;
  rv_pipe_pkg::reg_addr_t    rs2_e;
  rv_pipe_pkg::reg_addr_t    rd_e;
  rv_pipe_pkg::alu_op_e      alu_op_e;
  rv_pipe_pkg::alu_src_b_e   alu_src_b_e;
  rv_pipe_pkg::result_src_e  result_src_e;
  rv_pipe_pkg::branch_kind_e branch_kind_e;
  logic                      reg_write_e;
  logic                      mem_write_e;
  logic                      jalr_e;
  rv_pipe_pkg::word_t        rd1_e;
  rv_pipe_pkg::word_t        rd2_e;
  rv_pipe_pkg::word_t        imm_e;
  rv_pipe_pkg::word_t        pc_e;
  rv_pipe_pkg::word_t        alu_result_e;
  rv_pipe_pkg::word_t        store_data_e;
  rv_pipe_pkg::word_t        pc_target_e;
  rv_pipe_pkg::pc_src_e      pc_src_e;

  // Memory
  rv_pipe_pkg::reg_addr_t   rd_m;
  rv_pipe_pkg::result_src_e result_src_m;
  logic                     reg_write_m;
  logic                     mem_write_m;
  rv_pipe_pkg::word_t       alu_result_m;
  rv_pipe_pkg::word_t       store_data_m;
  rv_pipe_pkg::word_t       pc_step_m;
  rv_pipe_pkg::word_t       result_m;

  // Writeback
  rv_pipe_pkg::reg_addr_t   rd_w;
  rv_pipe_pkg::result_src_e result_src_w;
  logic                     reg_write_w;
  rv_pipe_pkg::word_t       result_pre_w;
  rv_pipe_pkg::word_t       read_data_w;
  rv_pipe_pkg::word_t       result_w;

  always_comb begin
    case (pc_src_e)
      rv_pipe_pkg::PC_SRC_STEP: pc_next = pc_f + `RV_PC_STEP;
      default:                  pc_next = pc_target_e;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_f <= `RV_RESET_PC;
    end else if (!stall_f) begin
      pc_f <= pc_next;
    end
  end

  assign instr_addr = pc_f;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_d <= `RV_NOP;
    end else if (flush_d) begin
      instr_d <= `RV_NOP;
    end else if (!stall_d) begin
      instr_d <= instr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_d) begin
      pc_d <= pc_f;
    end
  end

  rv_decoder i_decoder (
    .instr      (instr_d),
    .rs1        (rs1_d),
    .rs2        (rs2_d),
    .rd         (rd_d),
    .imm        (imm_d),
    .alu_op     (alu_op_d),
    .alu_src_b  (alu_src_b_d),
    .result_src (result_src_d),
    .branch_kind(branch_kind_d),
    .reg_write  (reg_write_d),
    .mem_write  (mem_write_d),
    .jalr       (jalr_d)
  );

  rv_register_file i_register_file (
    .clk  (clk),
    .rst_n(rst_n),
    .ra1  (rs1_d),
    .ra2  (rs2_d),
    .rd1  (rd1_d),
    .rd2  (rd2_d),
    .wa   (rd_w),
    .we   (reg_write_w),
    .wd   (result_w)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rs1_e         <= '0;
      rs2_e         <= '0;
      rd_e          <= '0;
      alu_op_e      <= rv_pipe_pkg::ALU_ADD;
      alu_src_b_e   <= rv_pipe_pkg::SRC_B_IMM;
      result_src_e  <= rv_pipe_pkg::RES_ALU;
      branch_kind_e <= rv_pipe_pkg::BR_NONE;
      reg_write_e   <= 1'b0;
      mem_write_e   <= 1'b0;
      jalr_e        <= 1'b0;
    end else if (flush_e) begin
      rs1_e         <= '0;
      rs2_e         <= '0;
      rd_e          <= '0;
      alu_op_e      <= rv_pipe_pkg::ALU_ADD;
      alu_src_b_e   <= rv_pipe_pkg::SRC_B_IMM;
      result_src_e  <= rv_pipe_pkg::RES_ALU;
      branch_kind_e <= rv_pipe_pkg::BR_NONE;
      reg_write_e   <= 1'b0;
      mem_write_e   <= 1'b0;
      jalr_e        <= 1'b0;
    end else begin
      rs1_e         <= rs1_d;
      rs2_e         <= rs2_d;
      rd_e          <= rd_d;
      alu_op_e      <= alu_op_d;
      alu_src_b_e   <= alu_src_b_d;
      result_src_e  <= result_src_d;
      branch_kind_e <= branch_kind_d;
      reg_write_e   <= reg_write_d;
      mem_write_e   <= mem_write_d;
      jalr_e        <= jalr_d;
    end
  end

  always_ff @(posedge clk) begin
    rd1_e <= rd1_d;
    rd2_e <= rd2_d;
    imm_e <= imm_d;
    pc_e  <= pc_d;
  end

  rv_execute_unit i_execute_unit (
    .rd1        (rd1_e),
    .rd2        (rd2_e),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .mem_result (result_m),
    .wb_result  (result_w),
    .imm        (imm_e),
    .pc         (pc_e),
    .alu_op     (alu_op_e),
    .alu_src_b  (alu_src_b_e),
    .branch_kind(branch_kind_e),
    .jalr       (jalr_e),
    .alu_result (alu_result_e),
    .store_data (store_data_e),
    .pc_target  (pc_target_e),
    .pc_src     (pc_src_e)
  );

  rv_hazard_unit i_hazard_unit (
    .rs1_d       (rs1_d),
    .rs2_d       (rs2_d),
    .rs1_e       (rs1_e),
    .rs2_e       (rs2_e),
    .rd_e        (rd_e),
    .rd_m        (rd_m),
    .rd_w        (rd_w),
    .reg_write_m (reg_write_m),
    .reg_write_w (reg_write_w),
    .result_src_e(result_src_e),
    .pc_src_e    (pc_src_e),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b),
    .stall_f     (stall_f),
    .stall_d     (stall_d),
    .flush_d     (flush_d),
    .flush_e     (flush_e)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_m         <= '0;
      result_src_m <= rv_pipe_pkg::RES_ALU;
      reg_write_m  <= 1'b0;
      mem_write_m  <= 1'b0;
    end else begin
      rd_m         <= rd_e;
      result_src_m <= result_src_e;
      reg_write_m  <= reg_write_e;
      mem_write_m  <= mem_write_e;
    end
  end

  always_ff @(posedge clk) begin
    alu_result_m <= alu_result_e;
    store_data_m <= store_data_e;
    pc_step_m    <= pc_e + `RV_PC_STEP;
  end

  assign data_addr  = alu_result_m;
  assign data_wdata = store_data_m;
  assign data_we    = mem_write_m;

  // Value offered to execute; load data is not ready yet
  assign result_m = (result_src_m == rv_pipe_pkg::RES_PC_STEP) ? pc_step_m : alu_result_m;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_w         <= '0;
      result_src_w <= rv_pipe_pkg::RES_ALU;
      reg_write_w  <= 1'b0;
    end else begin
      rd_w         <= rd_m;
      result_src_w <= result_src_m;
      reg_write_w  <= reg_write_m;
    end
  end

  always_ff @(posedge clk) begin
    result_pre_w <= result_m;
    read_data_w  <= data_rdata;
  end

  assign result_w = (result_src_w == rv_pipe_pkg::RES_MEM) ? read_data_w : result_pre_w;

endmodule

// File: bench/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 4;

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  end

  always #HALF_PERIOD clk = ~clk;

endmodule

// File: bench/rv_pipe_tb.sv
`include "rv_pipe_macros.svh"

module rv_pipe_tb;

  localparam int PROG_WORDS      = 64;
  localparam int RANDOM_WORDS    = 56;
  localparam int DATA_WORDS      = 32;
  localparam int WATCHDOG_CYCLES = PROG_WORDS * 4 + 40;
  localparam rv_pipe_pkg::word_t LOOP_PC = rv_pipe_pkg::word_t'((PROG_WORDS - 1) * 4);

  logic               clk;
  logic               rst_n;
  rv_pipe_pkg::word_t instr_addr;
  rv_pipe_pkg::word_t instr_data;
  rv_pipe_pkg::word_t data_addr;
  rv_pipe_pkg::word_t data_wdata;
  logic               data_we;
  rv_pipe_pkg::word_t data_rdata;

  rv_pipe_pkg::word_t imem [PROG_WORDS];
  rv_pipe_pkg::word_t dmem [DATA_WORDS];
  rv_pipe_pkg::word_t model_mem [DATA_WORDS];
  rv_pipe_pkg::word_t model_regs [32];
  rv_pipe_pkg::word_t exp_addr [$];
  rv_pipe_pkg::word_t exp_data [$];
  logic [15:0]        lfsr;
  int                 store_idx;
  int                 exp_count;

  tb_clock_gen i_clock_gen (
    .clk  (clk),
    .rst_n(rst_n)
  );

  rv_pipe_core i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .instr_addr(instr_addr),
    .instr_data(instr_data),
    .data_addr (data_addr),
    .data_wdata(data_wdata),
    .data_we   (data_we),
    .data_rdata(data_rdata)
  );

  // Both ports read in the same cycle
  assign instr_data = imem[instr_addr[7:2]];
  assign data_rdata = dmem[data_addr[6:2]];

  always @(posedge clk) begin
    if (data_we === 1'b1) begin
      dmem[data_addr[6:2]] <= data_wdata;
    end
  end

  // Galois LFSR stepped once per bit
  function automatic rv_pipe_pkg::word_t next_bits(input int count);
    rv_pipe_pkg::word_t value;
    logic               out_bit;
    value = '0;
    for (int i = 0; i < count; i++) begin
      out_bit = lfsr[0];
      lfsr    = {1'b0, lfsr[15:1]} ^ (out_bit ? 16'hB400 : 16'h0000);
      value   = {value[30:0], out_bit};
    end
    return value;
  endfunction

  function automatic rv_pipe_pkg::word_t r_type_word(input logic [6:0] funct7,
      input rv_pipe_pkg::reg_addr_t rs2, input rv_pipe_pkg::reg_addr_t rs1,
      input logic [2:0] funct3, input rv_pipe_pkg::reg_addr_t rd);
    rv_pipe_pkg::opcode_e opc;
    opc = rv_pipe_pkg::OPC_OP;
    return {funct7, rs2, rs1, funct3, rd, opc};
  endfunction

  function automatic rv_pipe_pkg::word_t i_type_word(input logic [11:0] imm,
      input rv_pipe_pkg::reg_addr_t rs1, input logic [2:0] funct3,
      input rv_pipe_pkg::reg_addr_t rd, input rv_pipe_pkg::opcode_e opc);
    return {imm, rs1, funct3, rd, opc};
  endfunction

  function automatic rv_pipe_pkg::word_t s_type_word(input logic [11:0] imm,
      input rv_pipe_pkg::reg_addr_t rs2, input rv_pipe_pkg::reg_addr_t rs1);
    rv_pipe_pkg::opcode_e opc;
    opc = rv_pipe_pkg::OPC_STORE;
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc};
  endfunction

  function automatic rv_pipe_pkg::word_t b_type_word(input logic [12:0] imm,
      input rv_pipe_pkg::reg_addr_t rs2, input rv_pipe_pkg::reg_addr_t rs1,
      input logic [2:0] funct3);
    rv_pipe_pkg::opcode_e opc;
    opc = rv_pipe_pkg::OPC_BRANCH;
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], opc};
  endfunction

  function automatic rv_pipe_pkg::word_t u_type_word(input logic [19:0] imm,
      input rv_pipe_pkg::reg_addr_t rd);
    rv_pipe_pkg::opcode_e opc;
    opc = rv_pipe_pkg::OPC_LUI;
    return {imm, rd, opc};
  endfunction

  function automatic rv_pipe_pkg::word_t j_type_word(input logic [20:0] imm,
      input rv_pipe_pkg::reg_addr_t rd);
    rv_pipe_pkg::opcode_e opc;
    opc = rv_pipe_pkg::OPC_JAL;
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
  endfunction

  task automatic fail_run();
    $display("** FAIL **");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_addr(input rv_pipe_pkg::word_t got, input rv_pipe_pkg::word_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: data_addr = %h, expected %h", $time, got, exp);
      fail_run();
    end
  endtask

  task automatic check_data(input rv_pipe_pkg::word_t got, input rv_pipe_pkg::word_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: data_wdata = %h, expected %h", $time, got, exp);
      fail_run();
    end
  endtask

  task automatic check_pc(input rv_pipe_pkg::word_t got, input rv_pipe_pkg::word_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: instr_addr = %h, expected %h", $time, got, exp);
      fail_run();
    end
  endtask

  task automatic build_program();
    int                     slot;
    int                     last_ctrl;
    int                     kind;
    int                     offset;
    int                     sel;
    rv_pipe_pkg::reg_addr_t rd;
    rv_pipe_pkg::reg_addr_t rs1;
    rv_pipe_pkg::reg_addr_t rs2;
    rv_pipe_pkg::reg_addr_t link;
    slot      = 0;
    last_ctrl = -10;
    while (slot < RANDOM_WORDS) begin
      kind   = int'(next_bits(3));
      rd     = 5'(next_bits(3));
      rs1    = 5'(next_bits(3));
      rs2    = 5'(next_bits(3));
      offset = (next_bits(1) != 0) ? 12 : 8;
      // No earlier jump may land inside the LUI/ADDI/JALR group
      if (kind == 7 && slot <= RANDOM_WORDS - 5 && slot >= last_ctrl + 3) begin
        link = 5'(next_bits(3) % 7 + 1);
        imem[slot]     = u_type_word(20'h0, link);
        imem[slot + 1] = i_type_word(12'((slot + 2) * 4 + offset) | 12'(next_bits(1)),
                                     link, 3'b000, link, rv_pipe_pkg::OPC_OP_IMM);
        imem[slot + 2] = i_type_word(12'h0, link, 3'b000, rd, rv_pipe_pkg::OPC_JALR);
        last_ctrl = slot + 2;
        slot += 3;
      end else if (kind == 6 && slot <= RANDOM_WORDS - 3) begin
        sel = int'(next_bits(2));
        if (sel == 3) begin
          imem[slot] = j_type_word(21'(offset), rd);
        end else begin
          imem[slot] = b_type_word(13'(offset), rs2, rs1, (sel == 1) ? 3'b001 : 3'b000);
        end
        last_ctrl = slot;
        slot += 1;
      end else begin
        case (kind)
          2: imem[slot] = i_type_word(12'(next_bits(12)), rs1, 3'b000, rd,
                                      rv_pipe_pkg::OPC_OP_IMM);
          3: imem[slot] = u_type_word(20'(next_bits(20)), rd);
          4: imem[slot] = i_type_word(12'(next_bits(4) * 4), 5'd0, 3'b010, rd,
                                      rv_pipe_pkg::OPC_LOAD);
          5: imem[slot] = s_type_word(12'(next_bits(4) * 4), rs2, 5'd0);
          default: begin
            case (next_bits(3) % 6)
              0: imem[slot] = r_type_word(7'h00, rs2, rs1, 3'b000, rd);
              1: imem[slot] = r_type_word(7'h20, rs2, rs1, 3'b000, rd);
              2: imem[slot] = r_type_word(7'h00, rs2, rs1, 3'b111, rd);
              3: imem[slot] = r_type_word(7'h00, rs2, rs1, 3'b110, rd);
              4: imem[slot] = r_type_word(7'h00, rs2, rs1, 3'b100, rd);
              default: imem[slot] = r_type_word(7'h00, rs2, rs1, 3'b010, rd);
            endcase
          end
        endcase
        slot += 1;
      end
    end
    // Register dump to 64..88 followed by a jump to itself
    for (int k = 1; k < 8; k++) begin
      imem[RANDOM_WORDS + k - 1] = s_type_word(12'(64 + 4 * (k - 1)), 5'(k), 5'd0);
    end
    imem[PROG_WORDS - 1] = j_type_word(21'h0, 5'd0);
    for (int d = 0; d < DATA_WORDS; d++) begin
      model_mem[d] = next_bits(32);
      dmem[d]      <= model_mem[d];
    end
  endtask

  // Sequential ISA execution up to the final loop
  task automatic run_model();
    rv_pipe_pkg::word_t pc;
    rv_pipe_pkg::word_t next_pc;
    rv_pipe_pkg::word_t instr;
    rv_pipe_pkg::word_t a;
    rv_pipe_pkg::word_t b;
    rv_pipe_pkg::word_t imm_i;
    rv_pipe_pkg::word_t imm_s;
    rv_pipe_pkg::word_t imm_b;
    rv_pipe_pkg::word_t imm_j;
    rv_pipe_pkg::word_t result;
    rv_pipe_pkg::word_t addr;
    logic               write_rd;
    int                 steps;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    pc    = `RV_RESET_PC;
    steps = 0;
    while (pc != LOOP_PC) begin
      instr    = imem[pc[7:2]];
      a        = model_regs[instr[19:15]];
      b        = model_regs[instr[24:20]];
      imm_i    = {{20{instr[31]}}, instr[31:20]};
      imm_s    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      imm_b    = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      imm_j    = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      next_pc  = pc + 32'd4;
      write_rd = 1'b1;
      result   = '0;
      case (rv_pipe_pkg::opcode_e'(instr[6:0]))
        rv_pipe_pkg::OPC_OP: begin
          case (instr[14:12])
            3'b000:  result = instr[30] ? a - b : a + b;
            3'b010:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  result = a ^ b;
            3'b110:  result = a | b;
            default: result = a & b;
          endcase
        end
        rv_pipe_pkg::OPC_OP_IMM: result = a + imm_i;
        rv_pipe_pkg::OPC_LUI:    result = {instr[31:12], 12'h000};
        rv_pipe_pkg::OPC_LOAD: begin
          addr   = a + imm_i;
          result = model_mem[addr[6:2]];
        end
        rv_pipe_pkg::OPC_STORE: begin
          write_rd = 1'b0;
          addr     = a + imm_s;
          model_mem[addr[6:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        rv_pipe_pkg::OPC_BRANCH: begin
          write_rd = 1'b0;
          // funct3 bit 0 selects BNE
          if ((instr[12] == 1'b0) == (a == b)) begin
            next_pc = pc + imm_b;
          end
        end
        rv_pipe_pkg::OPC_JAL: begin
          result  = pc + 32'd4;
          next_pc = pc + imm_j;
        end
        rv_pipe_pkg::OPC_JALR: begin
          result  = pc + 32'd4;
          next_pc = (a + imm_i) & ~32'd1;
        end
        default: write_rd = 1'b0;
      endcase
      if (write_rd && instr[11:7] != 5'd0) begin
        model_regs[instr[11:7]] = result;
      end
      pc = next_pc;
      steps++;
      if (steps > PROG_WORDS * 2) begin
        $display("Reference model did not reach the final loop");
        fail_run();
      end
    end
  endtask

  // Every store on the data port is compared in order
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      if (data_we !== 1'b0 && data_we !== 1'b1) begin
        $display("Data write enable is unknown at %0t", $time);
        fail_run();
      end else if (data_we) begin
        if (store_idx >= exp_count) begin
          $display("Unexpected extra store at %0t to address %h", $time, data_addr);
          fail_run();
        end else begin
          check_addr(data_addr, exp_addr[store_idx]);
          check_data(data_wdata, exp_data[store_idx]);
          store_idx++;
        end
      end
    end
  end

  initial begin
    lfsr      = 16'd8601;
    store_idx = 0;
    build_program();
    run_model();
    exp_count = exp_addr.size();
    $display("Program generated with %0d expected stores", exp_count);
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_pc(instr_addr, `RV_RESET_PC);
    wait (store_idx == exp_count);
    repeat (10) @(posedge clk);
    $display("** PASS **");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES + 2) @(posedge clk);
    $display("Program did not finish within %0d cycles after reset", WATCHDOG_CYCLES);
    fail_run();
  end

endmodule

// File: rv_pipe.f
+incdir+logic
logic/rv_pipe_pkg.sv
logic/rv_decoder.sv
logic/rv_register_file.sv
logic/rv_execute_unit.sv
logic/rv_hazard_unit.sv
logic/rv_pipe_core.sv
bench/tb_clock_gen.sv
bench/rv_pipe_tb.sv

// File: Makefile
TOP := rv_pipe_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f rv_pipe.f

obj_dir/V$(TOP): rv_pipe.f $(wildcard logic/*.sv logic/*.svh bench/*.sv)
	verilator --binary --timing --top-module $(TOP) -f rv_pipe.f

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@grep -qx '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log
